//--- Makefile
# Verilator build and run of the decode stage testbench

TOP := decode_tb
LOG := sim.log

.PHONY: all build lint clean

all: build
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

build:
	verilator --binary --timing --top-module $(TOP) -f build.f -Mdir obj_dir

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
logic/rv_isa_pkg.sv
logic/decode_ops_pkg.sv
logic/instr_decoder.sv
logic/decode_pc_ctrl.sv
logic/dx_pipe_reg.sv
logic/decode_stage.sv
sim/decode_tb.sv

//--- logic/decode_ops_pkg.sv
/*
 * Execute-side controls as produced by decode. No mul/div or CSR controls.
 * DX_CTRL_BUBBLE is a no-op with zero registers that execute may always accept.
 */

package decode_ops_pkg;

	import rv_isa_pkg::*;

	typedef logic [3:0] alu_op_t;
	typedef logic       alu_src_a_t;
	typedef logic       alu_src_b_t;
	typedef logic [3:0] mem_op_t;
	typedef logic [1:0] bcond_t;
	typedef logic [2:0] except_t;

	// ALU operations
	localparam alu_op_t ALUOP_ADD = 4'h0;
	localparam alu_op_t ALUOP_SUB = 4'h1;
	localparam alu_op_t ALUOP_LT  = 4'h2;
	localparam alu_op_t ALUOP_LTU = 4'h4;
	localparam alu_op_t ALUOP_AND = 4'h6;
	localparam alu_op_t ALUOP_OR  = 4'h7;
	localparam alu_op_t ALUOP_XOR = 4'h8;
	localparam alu_op_t ALUOP_SRL = 4'h9;
	localparam alu_op_t ALUOP_SRA = 4'ha;
	localparam alu_op_t ALUOP_SLL = 4'hb;

	localparam alu_src_a_t ALUSRCA_RS1 = 1'b0;
	localparam alu_src_a_t ALUSRCA_PC  = 1'b1;
	localparam alu_src_b_t ALUSRCB_RS2 = 1'b0;
	localparam alu_src_b_t ALUSRCB_IMM = 1'b1;

	// Memory operations, NONE outside the load/store range
	localparam mem_op_t MEMOP_LW   = 4'h0;
	localparam mem_op_t MEMOP_LH   = 4'h1;
	localparam mem_op_t MEMOP_LB   = 4'h2;
	localparam mem_op_t MEMOP_LHU  = 4'h3;
	localparam mem_op_t MEMOP_LBU  = 4'h4;
	localparam mem_op_t MEMOP_SW   = 4'h5;
	localparam mem_op_t MEMOP_SH   = 4'h6;
	localparam mem_op_t MEMOP_SB   = 4'h7;
	localparam mem_op_t MEMOP_NONE = 4'h8;

	// Branch taken when the ALU result matches
	localparam bcond_t BCOND_NEVER  = 2'h0;
	localparam bcond_t BCOND_ZERO   = 2'h1;
	localparam bcond_t BCOND_NZERO  = 2'h2;
	localparam bcond_t BCOND_ALWAYS = 2'h3;

	localparam except_t EXCEPT_NONE    = 3'h0;
	localparam except_t EXCEPT_ILLEGAL = 3'h1;
	localparam except_t EXCEPT_ECALL   = 3'h2;
	localparam except_t EXCEPT_EBREAK  = 3'h3;
	localparam except_t EXCEPT_MRET    = 3'h4;

	typedef struct packed {
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		reg_addr_t  rd;
		alu_src_a_t alusrc_a;
		alu_src_b_t alusrc_b;
		alu_op_t    aluop;
		mem_op_t    memop;
		bcond_t     branchcond;
		logic       jump_is_regoffs;
		logic       result_is_linkaddr;
		except_t    except;
	} dx_ctrl_t;

	localparam dx_ctrl_t DX_CTRL_BUBBLE = '{
		rs1: REG_X0, rs2: REG_X0, rd: REG_X0,
		alusrc_a: ALUSRCA_RS1, alusrc_b: ALUSRCB_RS2,
		aluop: ALUOP_ADD, memop: MEMOP_NONE, branchcond: BCOND_NEVER,
		jump_is_regoffs: 1'b0, result_is_linkaddr: 1'b0,
		except: EXCEPT_NONE
	};

endpackage

//--- logic/decode_pc_ctrl.sv
/*
 * Decode PC and handshakes. Jump requests are gated by execute stall,
 * so a word with a completed jump is always consumed in that same cycle.
 */

`timescale 1ns/1ps

module decode_pc_ctrl
	import rv_isa_pkg::*;
#(
	parameter addr_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic  clk,
	input  logic  rst_n,

	input  logic  fd_cir_vld_i,
	input  logic  x_stall_i,
	input  logic  f_jump_rdy_i,
	input  logic  f_jump_now_i,
	input  addr_t f_jump_target_i,
	input  logic  jump_pred_i,
	input  data_t jump_offs_i,

	output addr_t pc_o,
	output addr_t pc_next_o,
	output logic  d_stall_o,
	output logic  df_cir_use_o,
	output logic  d_jump_req_o,
	output addr_t d_jump_target_o
);

	addr_t pc;
	logic  d_starved;
	logic  jump_wait;

	// ========================================
	// Stall and consumption
	// ========================================
	assign d_starved = !fd_cir_vld_i;

	// Only ask for a jump when the word can also move into execute
	assign d_jump_req_o    = fd_cir_vld_i && jump_pred_i && !x_stall_i;
	assign d_jump_target_o = pc + jump_offs_i;

	// Fetch busy, request must be repeated
	assign jump_wait = d_jump_req_o && !f_jump_rdy_i;

	assign d_stall_o    = x_stall_i || d_starved || jump_wait;
	assign df_cir_use_o = !d_stall_o;

	// ========================================
	// PC register
	// ========================================
	assign pc_next_o = pc + INSTR_BYTES;
	assign pc_o      = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_VECTOR;
		end else if (f_jump_now_i) begin
			// Own predicted jump or an execute redirect
			pc <= f_jump_target_i;
		end else if (!d_stall_o) begin
			pc <= pc_next_o;
		end
	end

endmodule

//--- logic/decode_stage.sv
/*
 * RV32I decode stage, one instruction in flight. Fetch must hold the word
 * until df_cir_use_o is seen high at a rising edge.
 */

`timescale 1ns/1ps

module decode_stage
	import rv_isa_pkg::*;
	import decode_ops_pkg::*;
#(
	parameter addr_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic     clk,
	input  logic     rst_n,

	// Fetch side
	input  instr_t   fd_cir_i,
	input  logic     fd_cir_vld_i,
	output logic     df_cir_use_o,
	output logic     d_jump_req_o,
	output addr_t    d_jump_target_o,
	input  logic     f_jump_rdy_i,
	input  logic     f_jump_now_i,
	input  addr_t    f_jump_target_i,

	// Execute side
	output logic     d_stall_o,
	input  logic     x_stall_i,
	input  logic     flush_d_x_i,
	output dx_ctrl_t dx_ctrl_o,
	output data_t    dx_imm_o,
	output addr_t    dx_pc_o,
	output addr_t    dx_jump_target_o,
	output addr_t    dx_mispredict_addr_o
);

	dx_ctrl_t dec_ctrl;
	data_t    dec_imm;
	logic     jump_pred;
	data_t    jump_offs;
	addr_t    pc;
	addr_t    pc_next;

	instr_decoder i_decoder (
		.instr_i     (fd_cir_i),
		.ctrl_o      (dec_ctrl),
		.imm_o       (dec_imm),
		.jump_pred_o (jump_pred),
		.jump_offs_o (jump_offs)
	);

	decode_pc_ctrl #(
		.RESET_VECTOR (RESET_VECTOR)
	) i_pc_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.fd_cir_vld_i    (fd_cir_vld_i),
		.x_stall_i       (x_stall_i),
		.f_jump_rdy_i    (f_jump_rdy_i),
		.f_jump_now_i    (f_jump_now_i),
		.f_jump_target_i (f_jump_target_i),
		.jump_pred_i     (jump_pred),
		.jump_offs_i     (jump_offs),
		.pc_o            (pc),
		.pc_next_o       (pc_next),
		.d_stall_o       (d_stall_o),
		.df_cir_use_o    (df_cir_use_o),
		.d_jump_req_o    (d_jump_req_o),
		.d_jump_target_o (d_jump_target_o)
	);

	// Registered boundary into execute
	dx_pipe_reg i_dx_reg (
		.clk                  (clk),
		.rst_n                (rst_n),
		.x_stall_i            (x_stall_i),
		.flush_d_x_i          (flush_d_x_i),
		.d_stall_i            (d_stall_o),
		.f_jump_now_i         (f_jump_now_i),
		.f_jump_target_i      (f_jump_target_i),
		.pc_i                 (pc),
		.pc_next_i            (pc_next),
		.jump_target_i        (d_jump_target_o),
		.ctrl_i               (dec_ctrl),
		.imm_i                (dec_imm),
		.dx_ctrl_o            (dx_ctrl_o),
		.dx_imm_o             (dx_imm_o),
		.dx_pc_o              (dx_pc_o),
		.dx_jump_target_o     (dx_jump_target_o),
		.dx_mispredict_addr_o (dx_mispredict_addr_o)
	);

endmodule

//--- logic/dx_pipe_reg.sv
/*
 * Decode-to-execute register. Controls reset to the bubble, payload has no reset
 * and is only meaningful while the controls describe a real instruction.
 */

`timescale 1ns/1ps

module dx_pipe_reg
	import rv_isa_pkg::*;
	import decode_ops_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	input  logic     x_stall_i,
	input  logic     flush_d_x_i,
	input  logic     d_stall_i,
	input  logic     f_jump_now_i,
	input  addr_t    f_jump_target_i,
	input  addr_t    pc_i,
	input  addr_t    pc_next_i,
	input  addr_t    jump_target_i,
	input  dx_ctrl_t ctrl_i,
	input  data_t    imm_i,

	output dx_ctrl_t dx_ctrl_o,
	output data_t    dx_imm_o,
	output addr_t    dx_pc_o,
	output addr_t    dx_jump_target_o,
	output addr_t    dx_mispredict_addr_o
);

	logic  insert_bubble;
	addr_t pc_load;

	// Flush from execute, or decode has nothing to hand over
	assign insert_bubble = flush_d_x_i || (d_stall_i && !x_stall_i);

	// A late redirect goes straight to the execute PC
	assign pc_load = (flush_d_x_i && f_jump_now_i) ? f_jump_target_i : pc_i;

	// ========================================
	// Controls
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_ctrl_o <= DX_CTRL_BUBBLE;
		end else if (insert_bubble) begin
			dx_ctrl_o <= DX_CTRL_BUBBLE;
		end else if (!x_stall_i) begin
			dx_ctrl_o <= ctrl_i;
		end
	end

	// ========================================
	// Payload
	// ========================================
	always_ff @(posedge clk) begin
		if (!x_stall_i) begin
			dx_imm_o             <= imm_i;
			dx_jump_target_o     <= jump_target_i;
			// Fall-through address for a wrongly taken branch
			dx_mispredict_addr_o <= pc_next_i;
			dx_pc_o              <= pc_load;
		end
	end

endmodule

//--- logic/instr_decoder.sv
/*
 * Purely combinational RV32I decoder. Anything outside RV32I, including
 * M and CSR encodings, comes out as the bubble with an illegal exception.
 * FENCE and FENCE.I are no-ops. Only JAL and backward branches predict taken.
 */

`timescale 1ns/1ps

module instr_decoder
	import rv_isa_pkg::*;
	import decode_ops_pkg::*;
(
	input  instr_t   instr_i,
	output dx_ctrl_t ctrl_o,
	output data_t    imm_o,
	output logic     jump_pred_o,
	output data_t    jump_offs_o
);

	opcode_t  opcode;
	funct3_t  funct3;
	funct7_t  funct7;
	data_t    imm_i;
	data_t    imm_s;
	data_t    imm_b;
	data_t    imm_u;
	data_t    imm_j;
	alu_op_t  base_op;
	dx_ctrl_t ctrl;
	data_t    imm;
	logic     illegal;
	logic     jump_pred;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// ========================================
	// Immediate formats
	// ========================================
	assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'h000};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// Bit 3 splits JAL from the branch opcode
	assign jump_offs_o = instr_i[3] ? imm_j : imm_b;

	// ALU op picked by funct3 alone, the funct7 variants are patched below
	always_comb begin
		case (funct3)
			F3_ADD_SUB: base_op = ALUOP_ADD;
			F3_SLL:     base_op = ALUOP_SLL;
			F3_SLT:     base_op = ALUOP_LT;
			F3_SLTU:    base_op = ALUOP_LTU;
			F3_XOR:     base_op = ALUOP_XOR;
			F3_SRL_SRA: base_op = ALUOP_SRL;
			F3_OR:      base_op = ALUOP_OR;
			default:    base_op = ALUOP_AND;
		endcase
	end

	// ========================================
	// Control decode
	// ========================================
	always_comb begin
		// Register fields straight from the word, R-type defaults
		ctrl                    = DX_CTRL_BUBBLE;
		ctrl.rs1                = instr_i[19:15];
		ctrl.rs2                = instr_i[24:20];
		ctrl.rd                 = instr_i[11:7];
		imm                     = imm_i;
		illegal                 = 1'b0;
		jump_pred               = 1'b0;

		case (opcode)
			OPC_LUI: begin
				ctrl.rs1      = REG_X0;
				ctrl.rs2      = REG_X0;
				ctrl.alusrc_b = ALUSRCB_IMM;
				imm           = imm_u;
			end
			OPC_AUIPC: begin
				ctrl.rs1      = REG_X0;
				ctrl.rs2      = REG_X0;
				ctrl.alusrc_a = ALUSRCA_PC;
				ctrl.alusrc_b = ALUSRCB_IMM;
				imm           = imm_u;
			end
			OPC_JAL: begin
				// Target is resolved here, execute only writes the link
				ctrl.rs1                = REG_X0;
				ctrl.rs2                = REG_X0;
				ctrl.result_is_linkaddr = 1'b1;
				imm                     = imm_j;
				jump_pred               = 1'b1;
			end
			OPC_JALR: begin
				ctrl.rs2                = REG_X0;
				ctrl.alusrc_b           = ALUSRCB_IMM;
				ctrl.branchcond         = BCOND_ALWAYS;
				ctrl.jump_is_regoffs    = 1'b1;
				ctrl.result_is_linkaddr = 1'b1;
				illegal                 = funct3 != F3_JALR;
			end
			OPC_BRANCH: begin
				ctrl.rd   = REG_X0;
				imm       = imm_b;
				// Backward offset, so guess taken
				jump_pred = instr_i[31];
				case (funct3)
					F3_BEQ:  begin ctrl.aluop = ALUOP_SUB; ctrl.branchcond = BCOND_ZERO;  end
					F3_BNE:  begin ctrl.aluop = ALUOP_SUB; ctrl.branchcond = BCOND_NZERO; end
					F3_BLT:  begin ctrl.aluop = ALUOP_LT;  ctrl.branchcond = BCOND_NZERO; end
					F3_BGE:  begin ctrl.aluop = ALUOP_LT;  ctrl.branchcond = BCOND_ZERO;  end
					F3_BLTU: begin ctrl.aluop = ALUOP_LTU; ctrl.branchcond = BCOND_NZERO; end
					F3_BGEU: begin ctrl.aluop = ALUOP_LTU; ctrl.branchcond = BCOND_ZERO;  end
					default: illegal = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				ctrl.rs2      = REG_X0;
				ctrl.alusrc_b = ALUSRCB_IMM;
				case (funct3)
					F3_LB:   ctrl.memop = MEMOP_LB;
					F3_LH:   ctrl.memop = MEMOP_LH;
					F3_LW:   ctrl.memop = MEMOP_LW;
					F3_LBU:  ctrl.memop = MEMOP_LBU;
					F3_LHU:  ctrl.memop = MEMOP_LHU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				ctrl.rd       = REG_X0;
				ctrl.alusrc_b = ALUSRCB_IMM;
				imm           = imm_s;
				case (funct3)
					F3_SB:   ctrl.memop = MEMOP_SB;
					F3_SH:   ctrl.memop = MEMOP_SH;
					F3_SW:   ctrl.memop = MEMOP_SW;
					default: illegal = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				ctrl.rs2      = REG_X0;
				ctrl.alusrc_b = ALUSRCB_IMM;
				ctrl.aluop    = base_op;
				// Shift amounts live in rs2 slot, funct7 must be clean
				if (funct3 == F3_SLL) begin
					illegal = funct7 != F7_BASE;
				end else if (funct3 == F3_SRL_SRA) begin
					illegal = funct7 != F7_BASE && funct7 != F7_ALT;
					if (funct7 == F7_ALT)
						ctrl.aluop = ALUOP_SRA;
				end
			end
			OPC_OP: begin
				ctrl.aluop = base_op;
				if (funct7 == F7_ALT && funct3 == F3_ADD_SUB)
					ctrl.aluop = ALUOP_SUB;
				else if (funct7 == F7_ALT && funct3 == F3_SRL_SRA)
					ctrl.aluop = ALUOP_SRA;
				else if (funct7 != F7_BASE)
					illegal = 1'b1;
			end
			OPC_MISC_MEM: begin
				// Both fences are no-ops on this in-order core
				ctrl    = DX_CTRL_BUBBLE;
				illegal = funct3 != F3_FENCE && funct3 != F3_FENCE_I;
			end
			OPC_SYSTEM: begin
				ctrl = DX_CTRL_BUBBLE;
				if (instr_i == INSTR_ECALL)
					ctrl.except = EXCEPT_ECALL;
				else if (instr_i == INSTR_EBREAK)
					ctrl.except = EXCEPT_EBREAK;
				else if (instr_i == INSTR_MRET)
					ctrl.except = EXCEPT_MRET;
				else
					illegal = 1'b1;
			end
			default: illegal = 1'b1;
		endcase

		// Illegal words carry no side effects besides the trap
		if (illegal) begin
			ctrl        = DX_CTRL_BUBBLE;
			ctrl.except = EXCEPT_ILLEGAL;
			jump_pred   = 1'b0;
		end
	end

	assign ctrl_o      = ctrl;
	assign imm_o       = imm;
	assign jump_pred_o = jump_pred;

endmodule

//--- logic/rv_isa_pkg.sv
/*
 * RV32I base encodings only. No compressed, M or CSR encodings are defined.
 * Every instruction is 4 bytes wide, so the PC always steps by INSTR_BYTES.
 */

package rv_isa_pkg;

	// ========================================
	// Widths with a meaning
	// ========================================
	typedef logic [31:0] instr_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	localparam addr_t     INSTR_BYTES = 32'd4;
	localparam reg_addr_t REG_X0      = 5'd0;

	// Major opcodes, bits 6:0
	localparam opcode_t OPC_LUI      = 7'b0110111;
	localparam opcode_t OPC_AUIPC    = 7'b0010111;
	localparam opcode_t OPC_JAL      = 7'b1101111;
	localparam opcode_t OPC_JALR     = 7'b1100111;
	localparam opcode_t OPC_BRANCH   = 7'b1100011;
	localparam opcode_t OPC_LOAD     = 7'b0000011;
	localparam opcode_t OPC_STORE    = 7'b0100011;
	localparam opcode_t OPC_OP_IMM   = 7'b0010011;
	localparam opcode_t OPC_OP       = 7'b0110011;
	localparam opcode_t OPC_MISC_MEM = 7'b0001111;
	localparam opcode_t OPC_SYSTEM   = 7'b1110011;

	// Branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// Load and store widths
	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;
	localparam funct3_t F3_SB  = 3'b000;
	localparam funct3_t F3_SH  = 3'b001;
	localparam funct3_t F3_SW  = 3'b010;

	// ALU functions, shared by OP and OP-IMM
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	localparam funct3_t F3_JALR    = 3'b000;
	localparam funct3_t F3_FENCE   = 3'b000;
	localparam funct3_t F3_FENCE_I = 3'b001;

	// Base form and the SUB/SRA form
	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000;

	// Privileged words are matched whole
	localparam instr_t INSTR_ECALL  = 32'h0000_0073;
	localparam instr_t INSTR_EBREAK = 32'h0010_0073;
	localparam instr_t INSTR_MRET   = 32'h3020_0073;

endpackage

//--- sim/decode_tb.sv
/*
 * Testbench for the RV32I decode stage. Fetch and execute are modeled here.
 * One word is in flight. Fetch answers a jump request in the same cycle when ready.
 * Stops at the first mismatch. A watchdog bounds the run.
 */

`timescale 1ns/1ps

module decode_tb
	import rv_isa_pkg::*;
	import decode_ops_pkg::*;
;

	localparam addr_t RESET_VECTOR = 32'h0000_1000;
	localparam int    N_ALU        = 200;
	localparam int    N_MEM        = 60;
	localparam int    N_SPECIAL    = 9;
	localparam int    N_STALL      = 4;
	localparam int    N_BRANCH     = 8;
	localparam int    N_FLUSH      = 4;
	localparam int    N_WORDS      = N_ALU + N_MEM + N_SPECIAL + N_STALL + N_BRANCH + N_FLUSH;

	// Illegal words, privileged words and fences
	localparam instr_t SPECIALS [N_SPECIAL] = '{
		32'hffff_ffff, 32'h0000_0000, 32'h3400_1073, 32'h0220_80b3, 32'h0000_10e7,
		INSTR_ECALL, INSTR_EBREAK, INSTR_MRET, 32'h0ff0_000f
	};

	// Expected decode of one word
	typedef struct packed {
		dx_ctrl_t ctrl;
		data_t    imm;
		logic     imm_ok;
		logic     pred;
		logic     has_tgt;
		addr_t    target;
	} ref_t;

	logic     clk;
	logic     rst_n;
	instr_t   fd_cir_i;
	logic     fd_cir_vld_i;
	logic     f_jump_rdy_i;
	logic     x_stall_i;
	logic     flush_d_x_i;
	logic     redirect;
	addr_t    redir_target;
	logic     f_jump_now_i;
	addr_t    f_jump_target_i;
	logic     df_cir_use_o;
	logic     d_jump_req_o;
	addr_t    d_jump_target_o;
	logic     d_stall_o;
	dx_ctrl_t dx_ctrl_o;
	data_t    dx_imm_o;
	addr_t    dx_pc_o;
	addr_t    dx_jump_target_o;
	addr_t    dx_mispredict_addr_o;

	// Monitor state with the expected dx register one edge ahead
	string    test_name;
	addr_t    model_pc;
	ref_t     cur;
	logic     exp_req;
	logic     exp_use;
	dx_ctrl_t exp_ctrl;
	data_t    exp_imm;
	addr_t    exp_pc;
	addr_t    exp_jt;
	addr_t    exp_mis;
	logic     chk_imm;
	logic     chk_pc;
	logic     chk_jt;
	logic     chk_mis;
	instr_t   stall_words [N_STALL];

	decode_stage #(
		.RESET_VECTOR (RESET_VECTOR)
	) i_dut (
		.clk                  (clk),
		.rst_n                (rst_n),
		.fd_cir_i             (fd_cir_i),
		.fd_cir_vld_i         (fd_cir_vld_i),
		.df_cir_use_o         (df_cir_use_o),
		.d_jump_req_o         (d_jump_req_o),
		.d_jump_target_o      (d_jump_target_o),
		.f_jump_rdy_i         (f_jump_rdy_i),
		.f_jump_now_i         (f_jump_now_i),
		.f_jump_target_i      (f_jump_target_i),
		.d_stall_o            (d_stall_o),
		.x_stall_i            (x_stall_i),
		.flush_d_x_i          (flush_d_x_i),
		.dx_ctrl_o            (dx_ctrl_o),
		.dx_imm_o             (dx_imm_o),
		.dx_pc_o              (dx_pc_o),
		.dx_jump_target_o     (dx_jump_target_o),
		.dx_mispredict_addr_o (dx_mispredict_addr_o)
	);

	always #4 clk = ~clk;

	// Execute redirect wins over a ready own jump
	assign f_jump_now_i    = redirect || (d_jump_req_o && f_jump_rdy_i);
	assign f_jump_target_i = redirect ? redir_target : d_jump_target_o;

	// Fetch is busy about one cycle in four
	always @(posedge clk) begin
		#1;
		f_jump_rdy_i = ($urandom % 4) != 0;
	end

	// ========================================
	// Reference model
	// ========================================
	function automatic alu_op_t alu_for(input funct3_t f3);
		case (f3)
			3'b000:  return ALUOP_ADD;
			3'b001:  return ALUOP_SLL;
			3'b010:  return ALUOP_LT;
			3'b011:  return ALUOP_LTU;
			3'b100:  return ALUOP_XOR;
			3'b101:  return ALUOP_SRL;
			3'b110:  return ALUOP_OR;
			default: return ALUOP_AND;
		endcase
	endfunction

	function automatic ref_t ref_decode(input instr_t w, input addr_t pc);
		ref_t    r;
		data_t   i_imm;
		data_t   s_imm;
		data_t   b_imm;
		data_t   u_imm;
		data_t   j_imm;
		funct3_t f3;
		funct7_t f7;
		logic    bad;
		i_imm = {{20{w[31]}}, w[31:20]};
		s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
		b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		u_imm = {w[31:12], 12'b0};
		j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		f3    = w[14:12];
		f7    = w[31:25];
		bad   = 1'b0;
		r     = '0;
		r.ctrl     = DX_CTRL_BUBBLE;
		r.ctrl.rs1 = w[19:15];
		r.ctrl.rs2 = w[24:20];
		r.ctrl.rd  = w[11:7];
		r.imm      = i_imm;
		case (w[6:0])
			OPC_LUI, OPC_AUIPC: begin
				r.ctrl.rs1      = 5'd0;
				r.ctrl.rs2      = 5'd0;
				r.ctrl.alusrc_a = (w[6:0] == OPC_AUIPC) ? ALUSRCA_PC : ALUSRCA_RS1;
				r.ctrl.alusrc_b = ALUSRCB_IMM;
				r.imm           = u_imm;
				r.imm_ok        = 1'b1;
			end
			OPC_JAL: begin
				r.ctrl.rs1                = 5'd0;
				r.ctrl.rs2                = 5'd0;
				r.ctrl.result_is_linkaddr = 1'b1;
				r.imm                     = j_imm;
				r.imm_ok                  = 1'b1;
				r.pred                    = 1'b1;
				r.has_tgt                 = 1'b1;
				r.target                  = pc + j_imm;
			end
			OPC_JALR: begin
				bad                       = f3 != 3'b000;
				r.ctrl.rs2                = 5'd0;
				r.ctrl.alusrc_b           = ALUSRCB_IMM;
				r.ctrl.branchcond         = BCOND_ALWAYS;
				r.ctrl.jump_is_regoffs    = 1'b1;
				r.ctrl.result_is_linkaddr = 1'b1;
				r.imm_ok                  = 1'b1;
			end
			OPC_BRANCH: begin
				r.ctrl.rd = 5'd0;
				r.imm     = b_imm;
				r.imm_ok  = 1'b1;
				r.pred    = w[31];
				r.has_tgt = 1'b1;
				r.target  = pc + b_imm;
				// EQ/GE family tests for zero and NE/LT family for nonzero
				r.ctrl.branchcond = (f3[2] == f3[0]) ? BCOND_ZERO : BCOND_NZERO;
				case (f3[2:1])
					2'b00:   r.ctrl.aluop = ALUOP_SUB;
					2'b10:   r.ctrl.aluop = ALUOP_LT;
					2'b11:   r.ctrl.aluop = ALUOP_LTU;
					default: bad = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				r.ctrl.rs2      = 5'd0;
				r.ctrl.alusrc_b = ALUSRCB_IMM;
				r.imm_ok        = 1'b1;
				case (f3)
					3'b000:  r.ctrl.memop = MEMOP_LB;
					3'b001:  r.ctrl.memop = MEMOP_LH;
					3'b010:  r.ctrl.memop = MEMOP_LW;
					3'b100:  r.ctrl.memop = MEMOP_LBU;
					3'b101:  r.ctrl.memop = MEMOP_LHU;
					default: bad = 1'b1;
				endcase
			end
			OPC_STORE: begin
				r.ctrl.rd       = 5'd0;
				r.ctrl.alusrc_b = ALUSRCB_IMM;
				r.imm           = s_imm;
				r.imm_ok        = 1'b1;
				case (f3)
					3'b000:  r.ctrl.memop = MEMOP_SB;
					3'b001:  r.ctrl.memop = MEMOP_SH;
					3'b010:  r.ctrl.memop = MEMOP_SW;
					default: bad = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				r.ctrl.rs2      = 5'd0;
				r.ctrl.alusrc_b = ALUSRCB_IMM;
				r.ctrl.aluop    = alu_for(f3);
				r.imm_ok        = 1'b1;
				// Upper bits of a shift immediate select SRA or must be clear
				if (f3 == 3'b101 && f7 == F7_ALT)
					r.ctrl.aluop = ALUOP_SRA;
				else if (f3[1:0] == 2'b01 && f7 != F7_BASE)
					bad = 1'b1;
			end
			OPC_OP: begin
				r.ctrl.aluop = alu_for(f3);
				if (f7 == F7_ALT && f3 == 3'b000)
					r.ctrl.aluop = ALUOP_SUB;
				else if (f7 == F7_ALT && f3 == 3'b101)
					r.ctrl.aluop = ALUOP_SRA;
				else if (f7 != F7_BASE)
					bad = 1'b1;
			end
			OPC_MISC_MEM: begin
				r.ctrl = DX_CTRL_BUBBLE;
				bad    = f3 > 3'd1;
			end
			OPC_SYSTEM: begin
				r.ctrl = DX_CTRL_BUBBLE;
				case (w)
					INSTR_ECALL:  r.ctrl.except = EXCEPT_ECALL;
					INSTR_EBREAK: r.ctrl.except = EXCEPT_EBREAK;
					INSTR_MRET:   r.ctrl.except = EXCEPT_MRET;
					default:      bad = 1'b1;
				endcase
			end
			default: bad = 1'b1;
		endcase
		if (bad) begin
			r.ctrl        = DX_CTRL_BUBBLE;
			r.ctrl.except = EXCEPT_ILLEGAL;
			r.imm_ok      = 1'b0;
			r.pred        = 1'b0;
			r.has_tgt     = 1'b0;
		end
		return r;
	endfunction

	// ========================================
	// Checker and compare process
	// ========================================
	task automatic check_val(input string test, input string field,
			input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Error: test %s, %s expected %h actual %h", test, field, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch on %s", field);
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			exp_ctrl = DX_CTRL_BUBBLE;
			chk_imm  = 1'b0;
			chk_pc   = 1'b0;
			chk_jt   = 1'b0;
			chk_mis  = 1'b0;
			model_pc = RESET_VECTOR;
		end else begin
			// dx outputs against what the last edge should have loaded
			check_val(test_name, "dx_ctrl", 32'(exp_ctrl), 32'(dx_ctrl_o));
			if (chk_imm)
				check_val(test_name, "dx_imm", exp_imm, dx_imm_o);
			if (chk_pc)
				check_val(test_name, "dx_pc", exp_pc, dx_pc_o);
			if (chk_jt)
				check_val(test_name, "dx_jump_target", exp_jt, dx_jump_target_o);
			if (chk_mis)
				check_val(test_name, "dx_mispredict_addr", exp_mis, dx_mispredict_addr_o);

			// Zero-latency handshakes from the word now presented
			cur     = ref_decode(fd_cir_i, model_pc);
			exp_req = fd_cir_vld_i && cur.pred && !x_stall_i;
			exp_use = fd_cir_vld_i && !x_stall_i && !(exp_req && !f_jump_rdy_i);
			check_val(test_name, "d_jump_req", 32'(exp_req), 32'(d_jump_req_o));
			check_val(test_name, "df_cir_use", 32'(exp_use), 32'(df_cir_use_o));
			check_val(test_name, "d_stall", 32'(!exp_use), 32'(d_stall_o));
			if (exp_req)
				check_val(test_name, "d_jump_target", cur.target, d_jump_target_o);

			// Next dx contents with a bubble on flush or starvation
			if (flush_d_x_i)
				exp_ctrl = DX_CTRL_BUBBLE;
			else if (!x_stall_i)
				exp_ctrl = exp_use ? cur.ctrl : DX_CTRL_BUBBLE;
			if (!x_stall_i) begin
				chk_pc  = flush_d_x_i || exp_use;
				exp_pc  = (flush_d_x_i && redirect) ? redir_target : model_pc;
				chk_imm = exp_use && cur.imm_ok;
				exp_imm = cur.imm;
				chk_jt  = exp_use && cur.has_tgt;
				exp_jt  = cur.target;
				chk_mis = 1'b1;
				exp_mis = model_pc + 32'd4;
			end

			// PC follows a redirect, then an own jump, then the step
			if (redirect)
				model_pc = redir_target;
			else if (exp_req && f_jump_rdy_i)
				model_pc = cur.target;
			else if (exp_use)
				model_pc = model_pc + 32'd4;
		end
	end

	// ========================================
	// Fetch and execute stimulus
	// ========================================
	function automatic instr_t enc_branch(input funct3_t f3, input reg_addr_t rs1,
			input reg_addr_t rs2, input data_t offs);
		return {offs[12], offs[10:5], rs2, rs1, f3, offs[4:1], offs[11], OPC_BRANCH};
	endfunction

	function automatic instr_t enc_jal(input reg_addr_t rd, input data_t offs);
		return {offs[20], offs[10:1], offs[11], offs[19:12], rd, OPC_JAL};
	endfunction

	function automatic instr_t rand_alu_word();
		instr_t w;
		w = $urandom;
		case ($urandom % 4)
			0: begin
				w[6:0]   = OPC_OP;
				w[31:25] = ($urandom % 2) ? F7_ALT : F7_BASE;
			end
			1: begin
				w[6:0] = OPC_OP_IMM;
				// Half the time a clean shift form
				if ($urandom % 2)
					w[31:25] = ($urandom % 2) ? F7_ALT : F7_BASE;
			end
			2: w[6:0] = OPC_LUI;
			default: w[6:0] = OPC_AUIPC;
		endcase
		return w;
	endfunction

	function automatic instr_t rand_mem_word();
		instr_t w;
		w      = $urandom;
		w[6:0] = ($urandom % 2) ? OPC_LOAD : OPC_STORE;
		return w;
	endfunction

	// Present a word from 1 ns after an edge and hold it until consumed
	task automatic feed_word(input instr_t w);
		logic taken;
		fd_cir_i     = w;
		fd_cir_vld_i = 1'b1;
		taken        = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = df_cir_use_o;
			@(posedge clk);
			#1;
		end
		fd_cir_vld_i = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		fd_cir_i     = '0;
		fd_cir_vld_i = 1'b0;
		f_jump_rdy_i = 1'b1;
		x_stall_i    = 1'b0;
		flush_d_x_i  = 1'b0;
		redirect     = 1'b0;
		redir_target = '0;
		test_name    = "reset";
		void'($urandom(2));
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_name = "alu";
		for (int i = 0; i < N_ALU; i++)
			feed_word(rand_alu_word());

		test_name = "load_store";
		for (int i = 0; i < N_MEM; i++)
			feed_word(rand_mem_word());

		test_name = "exceptions";
		foreach (SPECIALS[k])
			feed_word(SPECIALS[k]);

		// Execute back-pressure over plain words and taken jumps
		test_name      = "stall";
		stall_words[0] = rand_alu_word();
		stall_words[1] = enc_branch(F3_BNE, 5'd3, 5'd4, -32'sd8);
		stall_words[2] = enc_jal(5'd1, 32'd64);
		stall_words[3] = rand_mem_word();
		foreach (stall_words[k]) begin
			x_stall_i = 1'b1;
			fork
				feed_word(stall_words[k]);
				begin
					repeat (1 + $urandom % 4) @(posedge clk);
					#1;
					x_stall_i = 1'b0;
				end
			join
		end
		test_name = "starve";
		idle_cycles(3);

		test_name = "branch";
		feed_word(enc_branch(F3_BEQ, 5'd1, 5'd2, -32'sd16));
		feed_word(enc_jal(5'd1, 32'h40));
		feed_word(enc_branch(F3_BNE, 5'd5, 5'd6, 32'd32));
		feed_word(enc_branch(F3_BLT, 5'd7, 5'd8, -32'sd8));
		feed_word(enc_jal(5'd0, -32'sd32));
		feed_word(enc_branch(F3_BGEU, 5'd9, 5'd10, 32'd12));
		feed_word(enc_branch(F3_BLTU, 5'd11, 5'd12, -32'sd4));
		feed_word(enc_branch(F3_BGE, 5'd13, 5'd14, 32'd2048));

		// Flush with a redirect over a word and then while idle
		test_name = "flush";
		fork
			feed_word(rand_alu_word());
			begin
				flush_d_x_i  = 1'b1;
				redirect     = 1'b1;
				redir_target = 32'h0000_2000;
				@(posedge clk);
				#1;
				flush_d_x_i = 1'b0;
				redirect    = 1'b0;
			end
		join
		flush_d_x_i  = 1'b1;
		redirect     = 1'b1;
		redir_target = 32'h0000_3000;
		idle_cycles(1);
		flush_d_x_i = 1'b0;
		redirect    = 1'b0;
		for (int i = 0; i < N_FLUSH - 1; i++)
			feed_word(rand_alu_word());
		idle_cycles(3);

		$display("SIMULATION PASSED");
		$finish;
	end

	// Each word gets 20 cycles at most
	initial begin
		repeat (N_WORDS * 20 + 20) @(posedge clk);
		$display("Timeout: the decode stage stopped consuming words");
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule
